// File: Makefile
# Verilator build and run of the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/core_if.sv
/*
 * core interfaces
 * execCtrlIf carries decoded control to the execute unit
 * commitIf gathers fault flags and returns the commit level
 */
interface execCtrlIf;
   import rvPkg::*;

   aluOp_t  aluOp;
   word_t   imm;            // selected immediate
   logic    useImm;         // operand b from imm
   logic    usePcA;         // operand a from pc, auipc
   logic    isBranch;
   funct3_t branchFunct3;
   logic    isJal;
   logic    isJalr;
   logic    isLoad;
   logic    isStore;
   logic    linkWr;         // write back pc+4
   logic    regWr;          // rd written, never for x0

   modport decodeSide (output aluOp, imm, useImm, usePcA, isBranch, branchFunct3,
                       isJal, isJalr, isLoad, isStore, linkWr, regWr);
   modport execSide (input aluOp, imm, useImm, usePcA, isBranch, branchFunct3,
                     isJal, isJalr, isLoad, isStore, linkWr, regWr);
endinterface

interface commitIf;
   logic illegal;           // from decoder
   logic dataMisaligned;    // from exec unit
   logic commit;            // from fetch unit

   modport decodeSide (output illegal);
   modport execSide (output dataMisaligned);
   modport fetchSide (input illegal, dataMisaligned, output commit);
   modport sinkSide (input commit);
endinterface

// File: hw/data_mem.sv
/*
 * data memory
 * word array, async read and write at the clock edge on committed stores
 */
`include "rv_consts.svh"

module data_mem (
   input  logic          clk,
   input  rvPkg::word_t  dataAddr,
   input  rvPkg::word_t  storeData,
   input  logic          isStore,
   commitIf.sinkSide     cmt,
   output rvPkg::word_t  loadData
);
   import rvPkg::*;

   word_t     dmem [2**`DMEM_WORDS_LOG2];
   dmemAddr_t wordIdx;

   // byte address to word index, upper bits ignored
   assign wordIdx = dataAddr[`DMEM_WORDS_LOG2+1:2];

   always_ff @(posedge clk) begin
      if (isStore && cmt.commit) begin
         dmem[wordIdx] <= storeData;
      end
   end

   assign loadData = dmem[wordIdx];   // same-cycle load data

endmodule

// File: hw/decoder.sv
/*
 * instruction decoder
 * field extraction, immediate select, rv32i legality and control levels
 */
`include "rv_consts.svh"

module decoder (
   input  rvPkg::word_t     instWord,
   output rvPkg::regAddr_t  rs1,
   output rvPkg::regAddr_t  rs2,
   output rvPkg::regAddr_t  rd,
   execCtrlIf.decodeSide    ctrl,
   commitIf.decodeSide      cmt
);
   import rvPkg::*;

   opcode_t    opcode;
   funct3_t    funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;
   aluOp_t     computeOp;   // shared by r-type and immediate forms
   logic       legal;
   logic       writesRd;

   assign opcode = instWord[6:0];
   assign rd     = instWord[11:7];
   assign funct3 = instWord[14:12];
   assign rs1    = instWord[19:15];
   assign rs2    = instWord[24:20];
   assign funct7 = instWord[31:25];

   // sign-extended immediates per format
   assign immI = {{20{instWord[31]}}, instWord[31:20]};
   assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
   assign immB = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};
   assign immU = {instWord[31:12], 12'b0};
   assign immJ = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};

   always_comb begin
      case (opcode)
         `OPCODE_STORE:               ctrl.imm = immS;
         `OPCODE_BRANCH:              ctrl.imm = immB;
         `OPCODE_LUI, `OPCODE_AUIPC:  ctrl.imm = immU;
         `OPCODE_JAL:                 ctrl.imm = immJ;
         default:                     ctrl.imm = immI;   // op-imm, load, jalr
      endcase
   end

   always_comb begin
      legal = 1'b0;
      case (opcode)
         `OPCODE_OP: begin
            // alt funct7 only for sub and sra
            legal = (funct7 == `FUNCT7_BASE) ||
                    ((funct7 == `FUNCT7_ALT) &&
                     ((funct3 == `FUNCT3_ADD_SUB) || (funct3 == `FUNCT3_SRL_SRA)));
         end
         `OPCODE_OP_IMM: begin
            case (funct3)
               `FUNCT3_SLL:     legal = (funct7 == `FUNCT7_BASE);
               `FUNCT3_SRL_SRA: legal = (funct7 == `FUNCT7_BASE) || (funct7 == `FUNCT7_ALT);
               default:         legal = 1'b1;          // upper bits are imm
            endcase
         end
         `OPCODE_LOAD:   legal = (funct3 == `FUNCT3_LW);   // word only
         `OPCODE_STORE:  legal = (funct3 == `FUNCT3_SW);
         `OPCODE_BRANCH: legal = funct3 inside {`FUNCT3_BEQ, `FUNCT3_BNE, `FUNCT3_BLT,
                                                `FUNCT3_BGE, `FUNCT3_BLTU, `FUNCT3_BGEU};
         `OPCODE_JALR:   legal = (funct3 == `FUNCT3_JALR);
         `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL: legal = 1'b1;
         default:        legal = 1'b0;   // also all-zero and all-one words
      endcase
   end

   assign cmt.illegal = !legal;

   // instWord[30] picks sra over srl, and sub over add in r-type only
   always_comb begin
      case (funct3)
         `FUNCT3_ADD_SUB: computeOp = ((opcode == `OPCODE_OP) && instWord[30]) ?
                                      `ALU_SUB : `ALU_ADD;
         `FUNCT3_SLL:     computeOp = `ALU_SLL;
         `FUNCT3_SLT:     computeOp = `ALU_SLT;
         `FUNCT3_SLTU:    computeOp = `ALU_SLTU;
         `FUNCT3_XOR:     computeOp = `ALU_XOR;
         `FUNCT3_SRL_SRA: computeOp = instWord[30] ? `ALU_SRA : `ALU_SRL;
         `FUNCT3_OR:      computeOp = `ALU_OR;
         default:         computeOp = `ALU_AND;
      endcase
   end

   always_comb begin
      ctrl.aluOp    = `ALU_ADD;   // address and target adds
      ctrl.useImm   = 1'b0;
      ctrl.usePcA   = 1'b0;
      ctrl.isBranch = 1'b0;
      ctrl.isJal    = 1'b0;
      ctrl.isJalr   = 1'b0;
      ctrl.isLoad   = 1'b0;
      ctrl.isStore  = 1'b0;
      ctrl.linkWr   = 1'b0;
      writesRd      = 1'b0;
      case (opcode)
         `OPCODE_OP: begin
            ctrl.aluOp = computeOp;
            writesRd   = 1'b1;
         end
         `OPCODE_OP_IMM: begin
            ctrl.aluOp  = computeOp;
            ctrl.useImm = 1'b1;
            writesRd    = 1'b1;
         end
         `OPCODE_LOAD: begin
            ctrl.useImm = 1'b1;
            ctrl.isLoad = 1'b1;
            writesRd    = 1'b1;
         end
         `OPCODE_STORE: begin
            ctrl.useImm  = 1'b1;
            ctrl.isStore = 1'b1;
         end
         `OPCODE_BRANCH: ctrl.isBranch = 1'b1;
         `OPCODE_LUI: begin
            ctrl.aluOp  = `ALU_PASS_B;
            ctrl.useImm = 1'b1;
            writesRd    = 1'b1;
         end
         `OPCODE_AUIPC: begin
            ctrl.usePcA = 1'b1;
            ctrl.useImm = 1'b1;
            writesRd    = 1'b1;
         end
         `OPCODE_JAL: begin
            ctrl.isJal  = 1'b1;
            ctrl.linkWr = 1'b1;
            writesRd    = 1'b1;
         end
         `OPCODE_JALR: begin
            ctrl.isJalr = 1'b1;
            ctrl.useImm = 1'b1;     // target = rs1 + imm
            ctrl.linkWr = 1'b1;
            writesRd    = 1'b1;
         end
         default: ;
      endcase
   end

   assign ctrl.branchFunct3 = funct3;
   assign ctrl.regWr = writesRd && (rd != '0);   // x0 writes are dropped

endmodule

// File: hw/exec_unit.sv
/*
 * execute unit
 * alu, branch compare, next-pc select, data address check and write-back mux
 */
`include "rv_consts.svh"

module exec_unit (
   input  rvPkg::word_t  pc,
   input  rvPkg::word_t  rdata1,
   input  rvPkg::word_t  rdata2,
   input  rvPkg::word_t  loadData,
   execCtrlIf.execSide   ctrl,
   commitIf.execSide     cmt,
   output rvPkg::word_t  nextPc,
   output rvPkg::word_t  dataAddr,
   output rvPkg::word_t  wrData
);
   import rvPkg::*;

   word_t      opA;
   word_t      opB;
   logic [4:0] shamt;
   word_t      aluResult;
   word_t      pcPlus4;
   word_t      pcRelTarget;   // branch and jal
   word_t      jalrTarget;
   logic       taken;

   assign opA   = ctrl.usePcA ? pc : rdata1;
   assign opB   = ctrl.useImm ? ctrl.imm : rdata2;
   assign shamt = opB[4:0];

   always_comb begin
      case (ctrl.aluOp)
         `ALU_ADD:    aluResult = opA + opB;
         `ALU_SUB:    aluResult = opA - opB;   // wraps on underflow
         `ALU_SLL:    aluResult = opA << shamt;
         `ALU_SLT:    aluResult = word_t'($signed(opA) < $signed(opB));
         `ALU_SLTU:   aluResult = word_t'(opA < opB);
         `ALU_XOR:    aluResult = opA ^ opB;
         `ALU_SRL:    aluResult = opA >> shamt;
         `ALU_SRA:    aluResult = word_t'($signed(opA) >>> shamt);
         `ALU_OR:     aluResult = opA | opB;
         `ALU_AND:    aluResult = opA & opB;
         `ALU_PASS_B: aluResult = opB;         // lui
         default:     aluResult = opA + opB;
      endcase
   end

   // branch condition on raw register values
   always_comb begin
      case (ctrl.branchFunct3)
         `FUNCT3_BEQ:  taken = (rdata1 == rdata2);
         `FUNCT3_BNE:  taken = (rdata1 != rdata2);
         `FUNCT3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
         `FUNCT3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
         `FUNCT3_BLTU: taken = (rdata1 < rdata2);
         `FUNCT3_BGEU: taken = (rdata1 >= rdata2);
         default:      taken = 1'b0;
      endcase
   end

   assign pcPlus4     = pc + 32'd4;
   assign pcRelTarget = pc + ctrl.imm;
   assign jalrTarget  = {aluResult[`WORD_WIDTH-1:1], 1'b0};   // bit 0 cleared

   always_comb begin
      if (ctrl.isJalr) begin
         nextPc = jalrTarget;
      end else if (ctrl.isJal || (ctrl.isBranch && taken)) begin
         nextPc = pcRelTarget;
      end else begin
         nextPc = pcPlus4;
      end
   end

   // rs1 + imm from the alu
   assign dataAddr = aluResult;
   assign cmt.dataMisaligned = (ctrl.isLoad || ctrl.isStore) && (dataAddr[1:0] != 2'b00);

   // zero when rd is not written
   always_comb begin
      if (!ctrl.regWr) begin
         wrData = '0;
      end else if (ctrl.linkWr) begin
         wrData = pcPlus4;
      end else if (ctrl.isLoad) begin
         wrData = loadData;
      end else begin
         wrData = aluResult;
      end
   end

endmodule

// File: hw/fetch_unit.sv
/*
 * fetch unit
 * pc register, instruction memory with program-load port,
 * commit forming and the sticky halt flag
 */
`include "rv_consts.svh"

module fetch_unit (
   input  logic              clk,
   input  logic              arstN,
   input  logic              progWrEn,
   input  rvPkg::imemAddr_t  progAddr,
   input  rvPkg::word_t      progData,
   input  rvPkg::word_t      nextPc,
   output rvPkg::word_t      pc,
   output rvPkg::word_t      instWord,
   output logic              halt,
   commitIf.fetchSide        cmt
);
   import rvPkg::*;

   word_t     imem [2**`IMEM_WORDS_LOG2];
   imemAddr_t fetchIdx;
   logic      fetchMisaligned;

   // program load, usable any time
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   assign fetchIdx = pc[`IMEM_WORDS_LOG2+1:2];   // word index, wraps past depth
   assign instWord = imem[fetchIdx];              // async read
   assign fetchMisaligned = (pc[1:0] != 2'b00);

   // any fault blocks the instruction
   assign cmt.commit = !halt && !cmt.illegal && !cmt.dataMisaligned && !fetchMisaligned;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc   <= `RESET_PC;
         halt <= 1'b0;
      end else begin
         if (cmt.commit) begin
            pc <= nextPc;          // pc frozen otherwise
         end
         if (!cmt.commit) begin
            halt <= 1'b1;          // sticky until reset
         end
      end
   end

endmodule

// File: hw/reg_file.sv
/*
 * register file
 * x1..x31 with two combinational reads, x0 reads as zero
 */
`include "rv_consts.svh"

module reg_file (
   input  logic             clk,
   input  rvPkg::regAddr_t  rs1,
   input  rvPkg::regAddr_t  rs2,
   input  rvPkg::regAddr_t  rd,
   input  rvPkg::word_t     wrData,
   input  logic             regWr,
   commitIf.sinkSide        cmt,
   output rvPkg::word_t     rdata1,
   output rvPkg::word_t     rdata2
);
   import rvPkg::*;

   word_t regs [1:`REG_COUNT-1];   // no storage for x0

   always_ff @(posedge clk) begin
      if (regWr && cmt.commit && (rd != '0)) begin
         regs[rd] <= wrData;
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/rv_consts.svh
/*
 * rv32i core constants
 * widths, memory depths, opcodes, funct fields and alu op codes
 */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define WORD_WIDTH      32
`define REG_COUNT       32
`define IMEM_WORDS_LOG2 8            // 256 instruction words
`define DMEM_WORDS_LOG2 8            // 256 data words
`define RESET_PC        32'h0000_0000

// major opcodes
`define OPCODE_OP       7'b0110011   // r-type computes
`define OPCODE_OP_IMM   7'b0010011   // immediate computes
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_LUI      7'b0110111
`define OPCODE_AUIPC    7'b0010111
`define OPCODE_JAL      7'b1101111
`define OPCODE_JALR     7'b1100111

// funct3, computes (shared by r-type and immediate forms)
`define FUNCT3_ADD_SUB  3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL_SRA  3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// funct3, branches
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

// funct3, word memory access and jalr
`define FUNCT3_LW       3'b010
`define FUNCT3_SW       3'b010
`define FUNCT3_JALR     3'b000

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000   // sub, sra, srai

// alu operations
`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_SLL         4'd2
`define ALU_SLT         4'd3
`define ALU_SLTU        4'd4
`define ALU_XOR         4'd5
`define ALU_SRL         4'd6
`define ALU_SRA         4'd7
`define ALU_OR          4'd8
`define ALU_AND         4'd9
`define ALU_PASS_B      4'd10        // lui

`endif

// File: hw/rv_core.sv
/*
 * rv32i single-cycle core, top level
 * program-load port in, halt and per-instruction retire trace out
 */
module rv_core (
   input  logic              clk,
   input  logic              arstN,
   input  logic              progWrEn,
   input  rvPkg::imemAddr_t  progAddr,
   input  rvPkg::word_t      progData,
   output logic              halt,
   output logic              retireValid,
   output rvPkg::word_t      retirePc,
   output rvPkg::regAddr_t   retireRd,
   output logic              retireWrEn,
   output rvPkg::word_t      retireData
);
   import rvPkg::*;

   word_t    pc;
   word_t    nextPc;
   word_t    instWord;
   regAddr_t rs1;
   regAddr_t rs2;
   regAddr_t rd;
   word_t    rdata1;
   word_t    rdata2;
   word_t    dataAddr;
   word_t    loadData;
   word_t    wrData;

   execCtrlIf ctrlBus ();
   commitIf   cmtBus ();

   fetch_unit i_fetch_unit (
      .clk      (clk),
      .arstN    (arstN),
      .progWrEn (progWrEn),
      .progAddr (progAddr),
      .progData (progData),
      .nextPc   (nextPc),
      .pc       (pc),
      .instWord (instWord),
      .halt     (halt),
      .cmt      (cmtBus.fetchSide)
   );

   decoder i_decoder (
      .instWord (instWord),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .ctrl     (ctrlBus.decodeSide),
      .cmt      (cmtBus.decodeSide)
   );

   exec_unit i_exec_unit (
      .pc       (pc),
      .rdata1   (rdata1),
      .rdata2   (rdata2),
      .loadData (loadData),
      .ctrl     (ctrlBus.execSide),
      .cmt      (cmtBus.execSide),
      .nextPc   (nextPc),
      .dataAddr (dataAddr),
      .wrData   (wrData)
   );

   reg_file i_reg_file (
      .clk    (clk),
      .rs1    (rs1),
      .rs2    (rs2),
      .rd     (rd),
      .wrData (wrData),
      .regWr  (ctrlBus.regWr),
      .cmt    (cmtBus.sinkSide),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   data_mem i_data_mem (
      .clk       (clk),
      .dataAddr  (dataAddr),
      .storeData (rdata2),     // rs2 for sw
      .isStore   (ctrlBus.isStore),
      .cmt       (cmtBus.sinkSide),
      .loadData  (loadData)
   );

   // retire trace, valid only with commit
   assign retireValid = cmtBus.commit;
   assign retirePc    = pc;
   assign retireRd    = rd;
   assign retireWrEn  = ctrlBus.regWr;
   assign retireData  = wrData;

endmodule

// File: hw/rv_pkg.sv
/*
 * rv32i shared types
 * vector typedefs for words, register indices, opcode fields and memory indices
 */
`include "rv_consts.svh"

package rvPkg;

   typedef logic [`WORD_WIDTH-1:0] word_t;        // data or address word

   typedef logic [4:0] regAddr_t;                 // x0..x31

   typedef logic [6:0] opcode_t;

   typedef logic [2:0] funct3_t;

   typedef logic [3:0] aluOp_t;                   // see ALU_* codes

   // word indices into the two memories
   typedef logic [`IMEM_WORDS_LOG2-1:0] imemAddr_t;
   typedef logic [`DMEM_WORDS_LOG2-1:0] dmemAddr_t;

endpackage

// File: sources.f
+incdir+hw
hw/rv_pkg.sv
hw/core_if.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/exec_unit.sv
hw/reg_file.sv
hw/data_mem.sv
hw/rv_core.sv
verification/core_tb.sv

// File: verification/core_tb.sv
/*
 * testbench for the rv32i single-cycle core
 * loads hand-encoded programs during reset, then checks the retire trace cycle by cycle
 */
module core_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import rvPkg::*;

   localparam int RESET_CYCLES   = 16;
   localparam int PROG_LEN       = 46;    // run 1 words, then run 2 words
   localparam int EXP_LEN        = 39;    // run 1 entries, then run 2 entries
   localparam int TIMEOUT_CYCLES = PROG_LEN + EXP_LEN + 2 * RESET_CYCLES + 20;

   // one expected retire cycle
   typedef struct packed {
      logic     valid;
      logic     halt;
      word_t    pc;
      regAddr_t rd;
      logic     wrEn;
      word_t    data;
   } retire_t;

   logic      clk;
   logic      arstN;
   logic      progWrEn;
   imemAddr_t progAddr;
   word_t     progData;
   logic      halt;
   logic      retireValid;
   word_t     retirePc;
   regAddr_t  retireRd;
   logic      retireWrEn;
   word_t     retireData;
   int        cycleCount = 0;

   // two words per line with fillers (addi x31) on the skipped slots
   word_t progTable [PROG_LEN] = '{
      32'h0050_0093, 32'hFFD0_0113,   // addi x1,x0,5    addi x2,x0,-3
      32'h0020_81B3, 32'h4011_8233,   // add x3,x1,x2    sub x4,x3,x1
      32'h0011_22B3, 32'h0011_3333,   // slt x5,x2,x1    sltu x6,x2,x1
      32'h4031_53B3, 32'h0031_5433,   // sra x7,x2,x3    srl x8,x2,x3
      32'h0030_94B3, 32'h0020_C533,   // sll x9,x1,x3    xor x10,x1,x2
      32'h0090_E5B3, 32'h0020_F633,   // or x11,x1,x9    and x12,x1,x2
      32'h0001_2693, 32'h0070_8013,   // slti x13,x2,0   addi x0,x1,7
      32'h0010_0733, 32'h1234_57B7,   // add x14,x0,x1   lui x15,0x12345
      32'h0000_1817, 32'h0080_08EF,   // auipc x16,1     jal x17,+8
      32'h0010_0F93, 32'h05D0_0913,   // filler          addi x18,x0,0x5d
      32'h0009_09E7, 32'h0010_0F93,   // jalr x19,0(x18) filler
      32'h0010_0F93, 32'h0010_8463,   // filler          beq x1,x1 taken
      32'h0010_0F93, 32'h0020_8463,   // filler          beq x1,x2
      32'h0020_9463, 32'h0010_0F93,   // bne x1,x2 taken filler
      32'h0010_9463, 32'h0011_4463,   // bne x1,x1       blt x2,x1 taken
      32'h0010_0F93, 32'h0020_C463,   // filler          blt x1,x2
      32'h0020_D463, 32'h0010_0F93,   // bge x1,x2 taken filler
      32'h0011_5463, 32'h0020_E463,   // bge x2,x1       bltu x1,x2 taken
      32'h0010_0F93, 32'h0011_6463,   // filler          bltu x2,x1
      32'h0011_7463, 32'h0010_0F93,   // bgeu x2,x1 taken filler
      32'h0020_F463, 32'h04A0_2023,   // bgeu x1,x2      sw x10,64(x0)
      32'h0400_2A03,                  // lw x20,64(x0)
      32'h0060_0093, 32'h0000_A103,   // run 2 addi x1,x0,6   misaligned lw x2,0(x1)
      32'h0000_0000                   // blank word that is never reached
   };

   // valid, halt, pc, rd, wrEn, data
   retire_t expTable [EXP_LEN] = '{
      '{1'b1, 1'b0, 32'h0000_0000, 5'd1,  1'b1, 32'h0000_0005},
      '{1'b1, 1'b0, 32'h0000_0004, 5'd2,  1'b1, 32'hFFFF_FFFD},
      '{1'b1, 1'b0, 32'h0000_0008, 5'd3,  1'b1, 32'h0000_0002},
      '{1'b1, 1'b0, 32'h0000_000C, 5'd4,  1'b1, 32'hFFFF_FFFD},   // 2 minus 5 wraps
      '{1'b1, 1'b0, 32'h0000_0010, 5'd5,  1'b1, 32'h0000_0001},   // signed -3 < 5
      '{1'b1, 1'b0, 32'h0000_0014, 5'd6,  1'b1, 32'h0000_0000},   // unsigned not less
      '{1'b1, 1'b0, 32'h0000_0018, 5'd7,  1'b1, 32'hFFFF_FFFF},   // sign fills
      '{1'b1, 1'b0, 32'h0000_001C, 5'd8,  1'b1, 32'h3FFF_FFFF},
      '{1'b1, 1'b0, 32'h0000_0020, 5'd9,  1'b1, 32'h0000_0014},
      '{1'b1, 1'b0, 32'h0000_0024, 5'd10, 1'b1, 32'hFFFF_FFF8},
      '{1'b1, 1'b0, 32'h0000_0028, 5'd11, 1'b1, 32'h0000_0015},   // 0x05 | 0x14
      '{1'b1, 1'b0, 32'h0000_002C, 5'd12, 1'b1, 32'h0000_0005},
      '{1'b1, 1'b0, 32'h0000_0030, 5'd13, 1'b1, 32'h0000_0001},
      '{1'b1, 1'b0, 32'h0000_0034, 5'd0,  1'b0, 32'h0000_0000},   // x0 write dropped
      '{1'b1, 1'b0, 32'h0000_0038, 5'd14, 1'b1, 32'h0000_0005},   // x0 still zero
      '{1'b1, 1'b0, 32'h0000_003C, 5'd15, 1'b1, 32'h1234_5000},
      '{1'b1, 1'b0, 32'h0000_0040, 5'd16, 1'b1, 32'h0000_1040},
      '{1'b1, 1'b0, 32'h0000_0044, 5'd17, 1'b1, 32'h0000_0048},   // link pc+4
      '{1'b1, 1'b0, 32'h0000_004C, 5'd18, 1'b1, 32'h0000_005D},
      '{1'b1, 1'b0, 32'h0000_0050, 5'd19, 1'b1, 32'h0000_0054},   // target 0x5d -> 0x5c
      '{1'b1, 1'b0, 32'h0000_005C, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0064, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0068, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0070, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0074, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_007C, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0080, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0088, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_008C, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0094, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_0098, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_00A0, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b1, 1'b0, 32'h0000_00A4, 5'd0,  1'b0, 32'h0000_0000},   // sw
      '{1'b1, 1'b0, 32'h0000_00A8, 5'd20, 1'b1, 32'hFFFF_FFF8},   // lw gets stored word
      '{1'b1, 1'b0, 32'h0000_0000, 5'd1,  1'b1, 32'h0000_0006},   // run 2
      '{1'b0, 1'b0, 32'h0000_0004, 5'd0,  1'b0, 32'h0000_0000},   // faulting lw
      '{1'b0, 1'b1, 32'h0000_0004, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b0, 1'b1, 32'h0000_0004, 5'd0,  1'b0, 32'h0000_0000},
      '{1'b0, 1'b1, 32'h0000_0004, 5'd0,  1'b0, 32'h0000_0000}
   };

   rv_core i_rv_core (
      .clk         (clk),
      .arstN       (arstN),
      .progWrEn    (progWrEn),
      .progAddr    (progAddr),
      .progData    (progData),
      .halt        (halt),
      .retireValid (retireValid),
      .retirePc    (retirePc),
      .retireRd    (retireRd),
      .retireWrEn  (retireWrEn),
      .retireData  (retireData)
   );

   always #20 clk = ~clk;   // 40 ns period

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Simulation FAILED");
         $fatal(1, "timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Error: %s expected 0x%08h, got 0x%08h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "retire trace mismatch at cycle %0d", cycleCount);
      end
   endtask

   // words go in while arstN is low, then 16 more reset cycles
   task automatic loadProgram(input int start, input int len);
      int i;
      @(posedge clk);
      arstN <= 1'b0;
      for (i = 0; i < len; i++) begin
         progWrEn <= 1'b1;
         progAddr <= imemAddr_t'(i);
         progData <= progTable[start + i];
         @(posedge clk);
      end
      progWrEn <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arstN <= 1'b1;           // first retire in the next cycle
   endtask

   // outputs settle after the rising edge and are sampled mid-cycle
   task automatic compareRetireTrace(input int start, input int len);
      retire_t e;
      int      i;
      for (i = 0; i < len; i++) begin
         @(negedge clk);
         e = expTable[start + i];
         checkValue("retireValid", 32'(e.valid), 32'(retireValid));
         checkValue("halt", 32'(e.halt), 32'(halt));
         checkValue("retirePc", e.pc, retirePc);
         if (e.valid) begin
            checkValue("retireWrEn", 32'(e.wrEn), 32'(retireWrEn));
            checkValue("retireData", e.data, retireData);
            if (e.wrEn) begin
               checkValue("retireRd", 32'(e.rd), 32'(retireRd));   // rd field is imm otherwise
            end
         end
      end
   endtask

   initial begin
      clk      = 1'b0;
      arstN    = 1'b0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      loadProgram(0, 43);       // alu, jumps, branches, word memory
      compareRetireTrace(0, 34);
      loadProgram(43, 3);       // misaligned load then halt
      compareRetireTrace(34, 5);
      $display("Simulation PASSED");
      $finish;
   end

endmodule
